//--- dsp_yaau.f
+incdir+src
src/dsp_yaau_pkg.sv
src/yaau_decode.sv
src/ram_addr_unit.sv
src/data_ram.sv
src/yaau_core.sv
verification/yaau_tb.sv

//--- src/data_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data RAM
// single-port word memory, registered read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "dsp_yaau_cfg.svh"

module data_ram (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  cen,
    input  wire [`YAAU_AW-1:0]   addr,
    input  wire [`YAAU_DW-1:0]   wdata,
    input  wire                  rd,
    input  wire                  wr,
    output logic [`YAAU_DW-1:0]  rdata
);

    logic [`YAAU_DW-1:0] mem [`YAAU_DEPTH];

    // contents start undefined
    always_ff @(posedge clk) begin
        if (cen && wr && !rst)
            mem[addr] <= wdata;
    end

    // read word holds until the next read
    always_ff @(posedge clk, posedge rst) begin
        if (rst)
            rdata <= '0;
        else if (cen && rd)
            rdata <= mem[addr];
    end

endmodule

`default_nettype wire

//--- src/dsp_yaau_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// YAAU configuration
// widths and sizes of the DSP data-memory addressing path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef DSP_YAAU_CFG_SVH
`define DSP_YAAU_CFG_SVH

// data path and address register width
`define YAAU_DW    16

// RAM address bits, low part of a pointer
`define YAAU_AW    11

// number of words in the data RAM, 2**YAAU_AW
`define YAAU_DEPTH 2048

// short immediate field of the instruction word
`define YAAU_SIW   9

`endif

//--- src/dsp_yaau_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// YAAU package
// operation codes, instruction word and decoder strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "dsp_yaau_cfg.svh"

package dsp_yaau_pkg;

    typedef enum logic [2:0] {
        op_nop        = 3'd0,
        op_load_short = 3'd1,   // r_field <- short immediate
        op_load_long  = 3'd2,   // r_field <- long immediate
        op_load_acc   = 3'd3,   // r_field <- accumulator
        op_load_ram   = 3'd4,   // r0..r3 <- last RAM read word
        op_read       = 3'd5,   // *y read, then post-modify
        op_write      = 3'd6    // *y = acc, then post-modify
    } yaau_op_e;

    // decoded instruction fields, op in the top bits
    typedef struct packed {
        yaau_op_e              op;
        logic [2:0]            r_field;   // r0-r3, j, k, rb, re
        logic [1:0]            y_field;   // pointer for the RAM access
        logic [1:0]            inc_sel;   // -1, 0, +1, +2
        logic                  ksel;      // k instead of j
        logic                  step_sel;  // j/k step instead of unit step
        logic [`YAAU_SIW-1:0]  short_imm;
        logic [`YAAU_DW-1:0]   long_imm;
    } yaau_instr_t;

    // one-hot style strobes seen by the address unit
    typedef struct packed {
        logic short_load;
        logic long_load;
        logic acc_load;
        logic ram_load;
        logic post_load;
        logic ram_rd;
        logic ram_wr;
    } yaau_ctl_t;

endpackage

`default_nettype wire

//--- src/ram_addr_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RAM address arithmetic unit
// pointers r0-r3, steps j/k and virtual shift register bounds
// rb/re; forms the RAM address and post-modifies the pointer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "dsp_yaau_cfg.svh"

module ram_addr_unit
    import dsp_yaau_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   cen,
    input  wire yaau_ctl_t        ctl,
    input  wire [2:0]             r_field,
    input  wire [1:0]             y_field,
    input  wire [1:0]             inc_sel,
    input  wire                   ksel,
    input  wire                   step_sel,
    input  wire [`YAAU_SIW-1:0]   short_imm,
    input  wire [`YAAU_DW-1:0]    long_imm,
    input  wire [`YAAU_DW-1:0]    acc,
    input  wire [`YAAU_DW-1:0]    ram_dout,
    output logic [`YAAU_AW-1:0]   ram_addr,
    output logic [`YAAU_DW-1:0]   reg_dout
);

    localparam int EXT = `YAAU_DW - `YAAU_SIW;

    logic [`YAAU_DW-1:0] rp [4];    // r0..r3
    logic [`YAAU_DW-1:0] j, k;
    logic [`YAAU_DW-1:0] rb, re;    // circular buffer begin / end

    logic [`YAAU_DW-1:0] rind;      // pointer picked by y_field
    logic [`YAAU_DW-1:0] unit_step;
    logic [`YAAU_DW-1:0] step;
    logic [`YAAU_DW-1:0] rsum;
    logic [`YAAU_DW-1:0] imm_sext, imm_zext;
    logic [`YAAU_DW-1:0] ld_sext, ld_zext;
    logic [`YAAU_DW-1:0] rnext;
    logic                imm_load;
    logic                reg_load;  // immediate or acc, any register
    logic                vsr_loop;
    logic [3:0]          load_r;
    logic                load_j, load_k, load_rb, load_re;

    assign imm_load = ctl.short_load | ctl.long_load;
    assign reg_load = imm_load | ctl.acc_load;

    // short immediates: signed for pointers and steps, unsigned for bounds
    assign imm_sext = ctl.long_load ? long_imm
                                    : {{EXT{short_imm[`YAAU_SIW-1]}}, short_imm};
    assign imm_zext = ctl.long_load ? long_imm : {{EXT{1'b0}}, short_imm};
    assign ld_sext  = imm_load ? imm_sext : acc;
    assign ld_zext  = imm_load ? imm_zext : acc;

    assign rind     = rp[y_field];
    assign reg_dout = rp[r_field[1:0]];
    assign ram_addr = rind[`YAAU_AW-1:0];

    always_comb begin
        case (inc_sel)
            2'd0:    unit_step = '1;    // -1
            2'd1:    unit_step = '0;
            2'd2:    unit_step = `YAAU_DW'(1);
            default: unit_step = `YAAU_DW'(2);
        endcase
    end

    assign step     = step_sel ? (ksel ? k : j) : unit_step;
    assign rsum     = rind + step;
    assign vsr_loop = (re != '0) && (rind == re);  // wrap only with re set

    // immediate, acc, RAM, wrap, sum
    always_comb begin
        if (imm_load)
            rnext = imm_sext;
        else if (ctl.acc_load)
            rnext = acc;
        else if (ctl.ram_load)
            rnext = ram_dout;
        else if (vsr_loop)
            rnext = rb;
        else
            rnext = rsum;
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            load_r[i] = ((reg_load | ctl.ram_load) && r_field == 3'(i))
                      || (ctl.post_load && y_field == 2'(i));
        end
        load_j  = reg_load && r_field == 3'd4;
        load_k  = reg_load && r_field == 3'd5;
        load_rb = reg_load && r_field == 3'd6;
        load_re = reg_load && r_field == 3'd7;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                rp[i] <= '0;
            end
            j  <= '0;
            k  <= '0;
            rb <= '0;
            re <= '0;
        end else if (cen) begin
            for (int i = 0; i < 4; i++) begin
                if (load_r[i])
                    rp[i] <= rnext;
            end
            if (load_j)  j  <= ld_sext;
            if (load_k)  k  <= ld_sext;
            if (load_rb) rb <= ld_zext;
            if (load_re) re <= ld_zext;
        end
    end

endmodule

`default_nettype wire

//--- src/yaau_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// YAAU core
// decoder, RAM address unit and data RAM of the DSP
// data-memory path; one instruction per enabled clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "dsp_yaau_cfg.svh"

module yaau_core
    import dsp_yaau_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  cen,
    input  wire yaau_instr_t     instr,
    input  wire [`YAAU_DW-1:0]   acc,
    output logic [`YAAU_AW-1:0]  ram_addr,
    output logic [`YAAU_DW-1:0]  reg_dout,
    output logic [`YAAU_DW-1:0]  rdata
);

    yaau_ctl_t ctl;

    yaau_decode u_decode (
        .op  (instr.op),
        .ctl (ctl)
    );

    // rdata loops back as the pointer load source
    ram_addr_unit u_aau (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .ctl       (ctl),
        .r_field   (instr.r_field),
        .y_field   (instr.y_field),
        .inc_sel   (instr.inc_sel),
        .ksel      (instr.ksel),
        .step_sel  (instr.step_sel),
        .short_imm (instr.short_imm),
        .long_imm  (instr.long_imm),
        .acc       (acc),
        .ram_dout  (rdata),
        .ram_addr  (ram_addr),
        .reg_dout  (reg_dout)
    );

    data_ram u_ram (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen),
        .addr  (ram_addr),
        .wdata (acc),       // only the accumulator is stored
        .rd    (ctl.ram_rd),
        .wr    (ctl.ram_wr),
        .rdata (rdata)
    );

endmodule

`default_nettype wire

//--- src/yaau_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// YAAU operation decoder
// turns the operation code into register load strobes and
// the RAM read and write enables
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module yaau_decode
    import dsp_yaau_pkg::*;
(
    input  wire yaau_op_e  op,
    output yaau_ctl_t      ctl
);

    always_comb begin
        ctl = '0;   // nop and unknown codes do nothing

        case (op)
            op_load_short: begin
                ctl.short_load = 1'b1;
            end

            op_load_long: begin
                ctl.long_load = 1'b1;
            end

            op_load_acc: begin
                ctl.acc_load = 1'b1;
            end

            // pointer copy from the registered RAM word
            op_load_ram: begin
                ctl.ram_load = 1'b1;
            end

            // access through y_field, pointer advances on the same edge
            op_read: begin
                ctl.post_load = 1'b1;
                ctl.ram_rd    = 1'b1;
            end

            op_write: begin
                ctl.post_load = 1'b1;
                ctl.ram_wr    = 1'b1;
            end

            default: begin
                ctl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verification/yaau_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// YAAU core testbench
// table of instructions with expected address, register and
// RAM outputs, applied one row per clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "dsp_yaau_cfg.svh"

module yaau_tb
    import dsp_yaau_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // rdata undefined here, not checked
    localparam logic [`YAAU_DW-1:0] rd_undef = 16'hxxxx;

    typedef struct {
        string                 name;
        yaau_instr_t           instr;
        logic [`YAAU_DW-1:0]   acc;
        logic                  cen;
        logic [`YAAU_AW-1:0]   exp_addr;
        logic [`YAAU_DW-1:0]   exp_dout;
        logic [`YAAU_DW-1:0]   exp_rdata;
    } row_t;

    logic                 clk;
    logic                 rst;
    logic                 cen;
    yaau_instr_t          instr;
    logic [`YAAU_DW-1:0]  acc;
    logic [`YAAU_AW-1:0]  ram_addr;
    logic [`YAAU_DW-1:0]  reg_dout;
    logic [`YAAU_DW-1:0]  rdata;

    row_t                 rows[$];
    logic [`YAAU_DW-1:0]  rnd [7];       // pseudo-random RAM words
    int                   cycle_count = 0;
    int                   cycle_limit = 1000000;

    yaau_core u_yaau_core (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .instr    (instr),
        .acc      (acc),
        .ram_addr (ram_addr),
        .reg_dout (reg_dout),
        .rdata    (rdata)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopped by the cycle limit");
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic make_words();
        logic [31:0] state;
        state = 32'ha431_0056;
        for (int n = 0; n < 7; n++) begin
            rnd[n] = '0;
            for (int b = 0; b < 16; b++) begin
                state  = lfsr_next(state);    // one step per bit
                rnd[n] = {rnd[n][14:0], state[0]};
            end
        end
    endtask

    // nop, immediate, acc and RAM loads
    function automatic yaau_instr_t load_instr(input yaau_op_e op, input logic [2:0] r,
                                               input logic [1:0] y, input logic [15:0] imm);
        yaau_instr_t ins;
        ins           = '0;
        ins.op        = op;
        ins.r_field   = r;
        ins.y_field   = y;
        ins.short_imm = imm[`YAAU_SIW-1:0];
        ins.long_imm  = imm;
        return ins;
    endfunction

    function automatic yaau_instr_t access_instr(input yaau_op_e op, input logic [1:0] y,
                                                 input logic [2:0] r, input logic [1:0] inc,
                                                 input logic ks, input logic ss);
        yaau_instr_t ins;
        ins          = '0;
        ins.op       = op;
        ins.y_field  = y;
        ins.r_field  = r;
        ins.inc_sel  = inc;
        ins.ksel     = ks;
        ins.step_sel = ss;
        return ins;
    endfunction

    task automatic add_row(input string name, input yaau_instr_t ins,
                           input logic [15:0] acc_v, input logic cen_v,
                           input logic [10:0] addr, input logic [15:0] dout,
                           input logic [15:0] rd);
        row_t r;
        r.name      = name;
        r.instr     = ins;
        r.acc       = acc_v;
        r.cen       = cen_v;
        r.exp_addr  = addr;
        r.exp_dout  = dout;
        r.exp_rdata = rd;
        rows.push_back(r);
    endtask

    task automatic compare_value(input string name, input string what,
                                 input logic [15:0] expected, input logic [15:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s (%s): expected %h, actual %h",
                     name, what, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopped at the first wrong value");
        end
    endtask

    task automatic build_table();
        // immediate and accumulator loads
        add_row("ld_r1_sneg", load_instr(op_load_short, 1, 0, 16'h01f0), 0, 1,
                11'h000, 16'h0000, 16'h0000);
        add_row("chk_r1_sext", load_instr(op_nop, 1, 0, 0), 0, 1,
                11'h000, 16'hfff0, 16'h0000);
        add_row("ld_r2_long", load_instr(op_load_long, 2, 0, 16'ha5c3), 0, 1,
                11'h000, 16'h0000, 16'h0000);
        add_row("chk_r2_long", load_instr(op_nop, 2, 0, 0), 0, 1,
                11'h000, 16'ha5c3, 16'h0000);
        add_row("ld_r3_acc", load_instr(op_load_acc, 3, 0, 0), 16'h7e11, 1,
                11'h000, 16'h0000, 16'h0000);
        add_row("chk_r3_acc", load_instr(op_nop, 3, 0, 0), 0, 1,
                11'h000, 16'h7e11, 16'h0000);
        add_row("ld_rb_zext", load_instr(op_load_short, 6, 0, 16'h01f0), 0, 1,
                11'h000, 16'ha5c3, 16'h0000);
        add_row("ld_re_five", load_instr(op_load_short, 7, 0, 16'h0005), 0, 1,
                11'h000, 16'h7e11, 16'h0000);
        add_row("ld_r0_five", load_instr(op_load_long, 0, 0, 16'h0005), 0, 1,
                11'h000, 16'h0000, 16'h0000);
        add_row("wrap_to_rb", access_instr(op_write, 0, 0, 2, 0, 0), 0, 1,
                11'h005, 16'h0005, 16'h0000);
        add_row("chk_rb_zext", load_instr(op_nop, 0, 0, 0), 0, 1,
                11'h1f0, 16'h01f0, 16'h0000);
        add_row("clr_re", load_instr(op_load_long, 7, 0, 16'h0000), 0, 1,
                11'h1f0, 16'h7e11, 16'h0000);
        // unit post-modify on r0
        add_row("inc_m1", access_instr(op_read, 0, 0, 0, 0, 0), 0, 1,
                11'h1f0, 16'h01f0, 16'h0000);
        add_row("inc_zero", access_instr(op_read, 0, 0, 1, 0, 0), 0, 1,
                11'h1ef, 16'h01ef, rd_undef);
        add_row("inc_p1", access_instr(op_read, 0, 0, 2, 0, 0), 0, 1,
                11'h1ef, 16'h01ef, rd_undef);
        add_row("inc_p2", access_instr(op_read, 0, 0, 3, 0, 0), 0, 1,
                11'h1f0, 16'h01f0, rd_undef);
        add_row("chk_inc_p2", load_instr(op_nop, 0, 0, 0), 0, 1,
                11'h1f2, 16'h01f2, rd_undef);
        // j = +3, k = -5
        add_row("ld_j", load_instr(op_load_short, 4, 0, 16'h0003), 0, 1,
                11'h1f2, 16'h01f2, rd_undef);
        add_row("ld_k", load_instr(op_load_short, 5, 0, 16'h01fb), 0, 1,
                11'h1f2, 16'hfff0, rd_undef);
        add_row("step_j", access_instr(op_read, 0, 0, 0, 0, 1), 0, 1,
                11'h1f2, 16'h01f2, rd_undef);
        add_row("step_k", access_instr(op_read, 0, 0, 0, 1, 1), 0, 1,
                11'h1f5, 16'h01f5, rd_undef);
        add_row("chk_step_k", load_instr(op_nop, 0, 0, 0), 0, 1,
                11'h1f0, 16'h01f0, rd_undef);
        // circular buffer 0x010..0x013 on r2
        add_row("ld_rb_vsr", load_instr(op_load_short, 6, 0, 16'h0010), 0, 1,
                11'h1f0, 16'ha5c3, rd_undef);
        add_row("ld_re_vsr", load_instr(op_load_short, 7, 0, 16'h0013), 0, 1,
                11'h1f0, 16'h7e11, rd_undef);
        add_row("ld_r2_vsr", load_instr(op_load_short, 2, 0, 16'h0010), 0, 1,
                11'h1f0, 16'ha5c3, rd_undef);
        for (int n = 0; n < 4; n++) begin
            add_row($sformatf("vsr_wr%0d", n), access_instr(op_write, 2, 2, 2, 0, 0),
                    rnd[n], 1, 11'(16 + n), 16'(16 + n), rd_undef);
        end
        add_row("vsr_rd0", access_instr(op_read, 2, 2, 2, 0, 0), 0, 1,
                11'h010, 16'h0010, rd_undef);
        for (int n = 1; n < 4; n++) begin
            add_row($sformatf("vsr_rd%0d", n), access_instr(op_read, 2, 2, 2, 0, 0),
                    0, 1, 11'(16 + n), 16'(16 + n), rnd[n - 1]);
        end
        add_row("ld_r0_ram", load_instr(op_load_ram, 0, 2, 0), 0, 1,
                11'h010, 16'h01f0, rnd[3]);
        add_row("chk_r0_ram", load_instr(op_nop, 0, 2, 0), 0, 1,
                11'h010, rnd[3], rnd[3]);
        // re = 0 turns the wrap off
        add_row("clr_re_vsr", load_instr(op_load_long, 7, 2, 16'h0000), 0, 1,
                11'h010, 16'h7e11, rnd[3]);
        add_row("ld_r2_end", load_instr(op_load_short, 2, 2, 16'h0013), 0, 1,
                11'h010, 16'h0010, rnd[3]);
        add_row("nowrap_wr", access_instr(op_write, 2, 2, 2, 0, 0), rnd[4], 1,
                11'h013, 16'h0013, rnd[3]);
        add_row("chk_nowrap", load_instr(op_nop, 2, 2, 0), 0, 1,
                11'h014, 16'h0014, rnd[3]);
        // stalls with cen low
        add_row("wr_keep", access_instr(op_write, 2, 2, 1, 0, 0), rnd[5], 1,
                11'h014, 16'h0014, rnd[3]);
        add_row("stall_wr", access_instr(op_write, 2, 2, 2, 0, 0), rnd[6], 0,
                11'h014, 16'h0014, rnd[3]);
        add_row("stall_ld", load_instr(op_load_long, 2, 2, 16'h0123), 0, 0,
                11'h014, 16'h0014, rnd[3]);
        add_row("stall_rd", access_instr(op_read, 2, 2, 2, 0, 0), 0, 0,
                11'h014, 16'h0014, rnd[3]);
        add_row("rd_keep", access_instr(op_read, 2, 2, 1, 0, 0), 0, 1,
                11'h014, 16'h0014, rnd[3]);
        add_row("chk_keep", load_instr(op_nop, 2, 2, 0), 0, 1,
                11'h014, 16'h0014, rnd[5]);
        add_row("dec_ptr", access_instr(op_read, 2, 2, 0, 0, 0), 0, 1,
                11'h014, 16'h0014, rnd[5]);
        add_row("rd_nowrap", access_instr(op_read, 2, 2, 1, 0, 0), 0, 1,
                11'h013, 16'h0013, rnd[5]);
        add_row("chk_nowrap_rd", load_instr(op_nop, 2, 2, 0), 0, 1,
                11'h013, 16'h0013, rnd[4]);
        // pointer at zero while re is zero, rb still 0x010
        add_row("ld_r2_zero", load_instr(op_load_short, 2, 2, 16'h0000), 0, 1,
                11'h013, 16'h0013, rnd[4]);
        add_row("zero_nowrap", access_instr(op_write, 2, 2, 2, 0, 0), 0, 1,
                11'h000, 16'h0000, rnd[4]);
        add_row("chk_zero_nowrap", load_instr(op_nop, 2, 2, 0), 0, 1,
                11'h001, 16'h0001, rnd[4]);
    endtask

    initial begin
        clk   = 1'b0;
        rst   = 1'b1;
        cen   = 1'b0;
        instr = '0;
        acc   = '0;

        make_words();
        build_table();
        cycle_limit = (rows.size() + 16) * 4;

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        foreach (rows[i]) begin
            @(posedge clk);
            instr <= rows[i].instr;
            acc   <= rows[i].acc;
            cen   <= rows[i].cen;
            @(negedge clk);     // mid cycle, before the edge that ends the row
            compare_value(rows[i].name, "ram_addr", 16'(rows[i].exp_addr), 16'(ram_addr));
            compare_value(rows[i].name, "reg_dout", rows[i].exp_dout, reg_dout);
            if (!$isunknown(rows[i].exp_rdata))
                compare_value(rows[i].name, "rdata", rows[i].exp_rdata, rdata);
        end

        @(posedge clk);
        cen   <= 1'b0;
        instr <= '0;
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
